// File: Bender.yml
package:
  name: pi1_soc

sources:
  - files:
      - hw/pi1_pkg.sv
      - hw/pi1_if.sv
      - hw/pi1_router.sv
      - hw/pi1_smem.sv
      - hw/pi1_uart.sv
      - hw/soc_top.sv
  - target: test
    files:
      - verification/soc_checker.sv
      - verification/soc_tb.sv

// File: compile.f
hw/pi1_pkg.sv
hw/pi1_if.sv
hw/pi1_router.sv
hw/pi1_smem.sv
hw/pi1_uart.sv
hw/soc_top.sv
verification/soc_checker.sv
verification/soc_tb.sv

// File: hw/pi1_if.sv
// one perint slave port, the router connects through mst and the slave through slv
`timescale 1ns/1ps

interface pi1_if import pi1_pkg::*; ();

	// request half, driven by the router
	pi1_op_e              op;
	logic [ADDRBITSZ-1:0] addr;
	logic [ARCHBITSZ-1:0] wdata;
	logic [SELBITSZ-1:0]  sel;

	// response half, driven by the slave
	logic [ARCHBITSZ-1:0] rdata;
	// completes the access in the cycle it is high
	logic                 rdy;

	// router side
	modport mst (
		output op,
		output addr,
		output wdata,
		output sel,
		input  rdata,
		input  rdy
	);

	// slave side
	modport slv (
		input  op,
		input  addr,
		input  wdata,
		input  sel,
		output rdata,
		output rdy
	);

endinterface

// File: hw/pi1_pkg.sv
// shared widths, opcodes, address map and uart timing, imported by the soc rtl and its testbench
package pi1_pkg;

	// one 32-bit word per bus access
	localparam int ARCHBITSZ = 32;
	// word address, the two byte offset bits are not carried
	localparam int ADDRBITSZ = 30;
	// one select bit per byte lane
	localparam int SELBITSZ  = ARCHBITSZ / 8;

	// perint operation codes
	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_WR  = 2'b01,
		PI1_RD  = 2'b10,
		PI1_RW  = 2'b11
	} pi1_op_e;

	// uart sits right below the memory, at byte 0x1000 minus 8
	localparam logic [ADDRBITSZ-1:0] UART_BASE  = 30'h3FE;
	localparam int                   UART_WORDS = 2;

	// 4 KB of on-chip memory starting at byte 0x1000
	localparam logic [ADDRBITSZ-1:0] RAM_BASE      = 30'h400;
	localparam int                   RAM_WORDS     = 1024;
	localparam int                   RAM_ADDRBITSZ = $clog2(RAM_WORDS);

	// bit period kept short so serial frames simulate quickly
	localparam int CLKS_PER_BIT    = 8;
	localparam int BAUDCNTBITSZ    = $clog2(CLKS_PER_BIT);
	localparam int RXFIFO_DEPTH    = 4;
	localparam int RXFIFO_PTRBITSZ = $clog2(RXFIFO_DEPTH);

	// bit positions in the uart status word
	localparam int UART_STAT_TXBUSY = 0;
	localparam int UART_STAT_RXNE   = 1;

endpackage

// File: hw/pi1_router.sv
// single-master perint router, steers each request to the uart, the memory or the invalid device
`timescale 1ns/1ps

module pi1_router import pi1_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  pi1_op_e              m_op_i,
	input  logic [ADDRBITSZ-1:0] m_addr_i,
	input  logic [ARCHBITSZ-1:0] m_data_i,
	input  logic [SELBITSZ-1:0]  m_sel_i,
	output logic [ARCHBITSZ-1:0] m_data_o,
	output logic                 m_rdy_o,
	pi1_if.mst                   ram_o,
	pi1_if.mst                   uart_o
);

	// slave selected by the address decode
	typedef enum logic [1:0] {
		TGT_UART,
		TGT_RAM,
		TGT_INV
	} tgt_e;

	tgt_e tgt_dec;
	tgt_e tgt_q;
	tgt_e tgt;
	logic inflight_q;

	// address map decode, anything outside both windows falls to the invalid device
	always_comb begin
		if (m_addr_i >= UART_BASE &&
			m_addr_i < UART_BASE + ADDRBITSZ'(UART_WORDS)) begin
			tgt_dec = TGT_UART;
		end else if (m_addr_i >= RAM_BASE &&
			m_addr_i < RAM_BASE + ADDRBITSZ'(RAM_WORDS)) begin
			tgt_dec = TGT_RAM;
		end else begin
			tgt_dec = TGT_INV;
		end
	end

	// set when a request goes out, cleared on the completing cycle
	// while set, the request stays tied to the slave it was issued to
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			inflight_q <= 1'b0;
		end else if (m_rdy_o) begin
			inflight_q <= 1'b0;
		end else if (m_op_i != PI1_NOP) begin
			inflight_q <= 1'b1;
		end
	end

	// owner of the outstanding request
	always_ff @(posedge clk_i) begin
		if (!inflight_q) begin
			tgt_q <= tgt_dec;
		end
	end

	assign tgt = inflight_q ? tgt_q : tgt_dec;

	// memory port, offset is relative to the start of ram
	assign ram_o.op    = (tgt == TGT_RAM) ? m_op_i : PI1_NOP;
	assign ram_o.addr  = m_addr_i - RAM_BASE;
	assign ram_o.wdata = m_data_i;
	assign ram_o.sel   = m_sel_i;

	// uart port, offset 0 is data and offset 1 is status
	assign uart_o.op    = (tgt == TGT_UART) ? m_op_i : PI1_NOP;
	assign uart_o.addr  = m_addr_i - UART_BASE;
	assign uart_o.wdata = m_data_i;
	assign uart_o.sel   = m_sel_i;

	// response mux back to the master
	always_comb begin
		case (tgt)
			TGT_UART: begin
				m_data_o = uart_o.rdata;
				m_rdy_o  = uart_o.rdy;
			end
			TGT_RAM: begin
				m_data_o = ram_o.rdata;
				m_rdy_o  = ram_o.rdy;
			end
			default: begin
				// invalid device answers at once with zero
				m_data_o = '0;
				m_rdy_o  = 1'b1;
			end
		endcase
	end

endmodule

// File: hw/pi1_smem.sv
// 4 KB on-chip memory slave on a perint port, supports byte-selected write, read and swap
`timescale 1ns/1ps

module pi1_smem import pi1_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	pi1_if.slv  bus_i
);

	// storage, cleared at start so unwritten words read back as zero
	logic [ARCHBITSZ-1:0]     mem_q [RAM_WORDS] = '{default: '0};
	logic [RAM_ADDRBITSZ-1:0] idx;
	logic [ARCHBITSZ-1:0]     rdata_q;
	logic                     phase_q;
	logic                     start;
	logic                     wr_en;

	// offset from the router is already ram relative
	assign idx = bus_i.addr[RAM_ADDRBITSZ-1:0];

	// an access starts on any op seen while not answering
	assign start = (bus_i.op != PI1_NOP) && !phase_q;
	// write and swap both store the selected bytes
	assign wr_en = (bus_i.op == PI1_WR) || (bus_i.op == PI1_RW);

	// phase is the one-cycle rdy pulse after each start
	// the low cycle that follows lets the next op be sampled
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			phase_q <= 1'b0;
		end else begin
			phase_q <= start;
		end
	end

	// old word captured together with the write, which gives swap its result
	always_ff @(posedge clk_i) begin
		if (start) begin
			rdata_q <= mem_q[idx];
		end
	end

	// byte lanes written only where sel is set
	always_ff @(posedge clk_i) begin
		if (start && wr_en) begin
			for (int b = 0; b < SELBITSZ; b++) begin
				if (bus_i.sel[b]) begin
					mem_q[idx][b*8 +: 8] <= bus_i.wdata[b*8 +: 8];
				end
			end
		end
	end

	assign bus_i.rdata = rdata_q;
	assign bus_i.rdy   = phase_q;

endmodule

// File: hw/pi1_uart.sv
// uart slave on a perint port, 8N1 transmitter with holding register, receiver and rx fifo
`timescale 1ns/1ps

module pi1_uart import pi1_pkg::*; (
	input  logic clk_i,
	input  logic rst_i,
	pi1_if.slv   bus_i,
	input  logic rx_i,
	output logic tx_o
);

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	// bus side
	logic                      phase_q;
	logic [ARCHBITSZ-1:0]      rdata_q;
	logic [ARCHBITSZ-1:0]      status;
	logic                      is_data;
	logic                      rd_data;
	logic                      wr_data;
	logic                      accept;
	// transmitter
	tx_state_e                 tx_state_q;
	logic [BAUDCNTBITSZ-1:0]   tx_cnt_q;
	logic [2:0]                tx_bit_q;
	logic [7:0]                tx_sh_q;
	logic [7:0]                hold_q;
	logic                      hold_v_q;
	logic                      tx_tick;
	logic                      tx_busy;
	// receiver
	rx_state_e                 rx_state_q;
	logic [1:0]                rx_sync_q;
	logic [BAUDCNTBITSZ-1:0]   rx_cnt_q;
	logic [2:0]                rx_bit_q;
	logic [7:0]                rx_sh_q;
	logic                      rx_tick;
	logic                      rx_push;
	// receive fifo, pointers carry one wrap bit
	logic [7:0]                fifo_q [RXFIFO_DEPTH];
	logic [RXFIFO_PTRBITSZ:0]  wr_ptr_q;
	logic [RXFIFO_PTRBITSZ:0]  rd_ptr_q;
	logic                      fifo_empty;
	logic                      fifo_full;
	logic                      fifo_pop;

	// offset 0 is the data word, offset 1 the status word
	assign is_data = (bus_i.addr[0] == 1'b0);
	// swap on data behaves like a read
	assign rd_data = is_data && (bus_i.op == PI1_RD || bus_i.op == PI1_RW);
	assign wr_data = is_data && (bus_i.op == PI1_WR) && bus_i.sel[0];
	// data write stalls with rdy low until the holding register frees
	assign accept   = (bus_i.op != PI1_NOP) && !phase_q && !(wr_data && hold_v_q);
	assign fifo_pop = accept && rd_data && !fifo_empty;

	always_comb begin
		status = '0;
		status[UART_STAT_TXBUSY] = tx_busy;
		status[UART_STAT_RXNE]   = !fifo_empty;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			phase_q <= 1'b0;
		end else begin
			phase_q <= accept;
		end
	end

	// empty fifo reads and all writes return zero
	always_ff @(posedge clk_i) begin
		if (accept) begin
			if (!is_data) begin
				rdata_q <= status;
			end else if (fifo_pop) begin
				rdata_q <= {{(ARCHBITSZ-8){1'b0}}, fifo_q[rd_ptr_q[RXFIFO_PTRBITSZ-1:0]]};
			end else begin
				rdata_q <= '0;
			end
		end
	end

	assign bus_i.rdata = rdata_q;
	assign bus_i.rdy   = phase_q;

	// busy also covers a byte still waiting in the holding register
	assign tx_busy = (tx_state_q != TX_IDLE) || hold_v_q;
	assign tx_tick = (tx_cnt_q == BAUDCNTBITSZ'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			tx_state_q <= TX_IDLE;
			tx_cnt_q   <= '0;
			tx_bit_q   <= '0;
			hold_v_q   <= 1'b0;
		end else begin
			tx_cnt_q <= (tx_state_q == TX_IDLE || tx_tick) ? '0 : tx_cnt_q + 1'b1;
			if (accept && wr_data) begin
				hold_v_q <= 1'b1;
			end
			case (tx_state_q)
				TX_IDLE: begin
					// move the held byte into the shifter and start a frame
					if (hold_v_q) begin
						hold_v_q   <= 1'b0;
						tx_state_q <= TX_START;
					end
				end
				TX_START: begin
					if (tx_tick) begin
						tx_bit_q   <= '0;
						tx_state_q <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (tx_tick) begin
						tx_bit_q <= tx_bit_q + 1'b1;
						if (tx_bit_q == 3'd7) begin
							tx_state_q <= TX_STOP;
						end
					end
				end
				default: begin
					if (tx_tick) begin
						tx_state_q <= TX_IDLE;
					end
				end
			endcase
		end
	end

	// lsb goes out first, shift after each data bit
	always_ff @(posedge clk_i) begin
		if (accept && wr_data) begin
			hold_q <= bus_i.wdata[7:0];
		end
		if (tx_state_q == TX_IDLE && hold_v_q) begin
			tx_sh_q <= hold_q;
		end else if (tx_state_q == TX_DATA && tx_tick) begin
			tx_sh_q <= tx_sh_q >> 1;
		end
	end

	// line idles high
	always_comb begin
		case (tx_state_q)
			TX_START: tx_o = 1'b0;
			TX_DATA:  tx_o = tx_sh_q[0];
			default:  tx_o = 1'b1;
		endcase
	end

	// two flops against metastability on the serial input
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rx_sync_q <= 2'b11;
		end else begin
			rx_sync_q <= {rx_sync_q[0], rx_i};
		end
	end

	assign rx_tick = (rx_cnt_q == BAUDCNTBITSZ'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rx_state_q <= RX_IDLE;
			rx_cnt_q   <= '0;
			rx_bit_q   <= '0;
		end else begin
			rx_cnt_q <= rx_tick ? '0 : rx_cnt_q + 1'b1;
			case (rx_state_q)
				RX_IDLE: begin
					rx_cnt_q <= '0;
					if (!rx_sync_q[1]) begin
						rx_state_q <= RX_START;
					end
				end
				RX_START: begin
					// half a bit in, a high line was only a glitch
					if (rx_cnt_q == BAUDCNTBITSZ'(CLKS_PER_BIT / 2 - 1)) begin
						rx_cnt_q   <= '0;
						rx_bit_q   <= '0;
						rx_state_q <= rx_sync_q[1] ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (rx_tick) begin
						rx_bit_q <= rx_bit_q + 1'b1;
						if (rx_bit_q == 3'd7) begin
							rx_state_q <= RX_STOP;
						end
					end
				end
				default: begin
					if (rx_tick) begin
						rx_state_q <= RX_IDLE;
					end
				end
			endcase
		end
	end

	// mid-bit samples shift in from the top
	always_ff @(posedge clk_i) begin
		if (rx_state_q == RX_DATA && rx_tick) begin
			rx_sh_q <= {rx_sync_q[1], rx_sh_q[7:1]};
		end
	end

	// bad stop bit or full fifo drops the byte
	assign rx_push = (rx_state_q == RX_STOP) && rx_tick && rx_sync_q[1] && !fifo_full;

	assign fifo_empty = (wr_ptr_q == rd_ptr_q);
	assign fifo_full  = (wr_ptr_q[RXFIFO_PTRBITSZ] != rd_ptr_q[RXFIFO_PTRBITSZ]) &&
		(wr_ptr_q[RXFIFO_PTRBITSZ-1:0] == rd_ptr_q[RXFIFO_PTRBITSZ-1:0]);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (rx_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (fifo_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rx_push) begin
			fifo_q[wr_ptr_q[RXFIFO_PTRBITSZ-1:0]] <= rx_sh_q;
		end
	end

endmodule

// File: hw/soc_top.sv
// soc top level, the external bus master drives the router which serves the memory and uart
`timescale 1ns/1ps

module soc_top import pi1_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_i,
	// master port, driven by a cpu or a trace player
	input  pi1_op_e              m_op_i,
	input  logic [ADDRBITSZ-1:0] m_addr_i,
	input  logic [ARCHBITSZ-1:0] m_data_i,
	input  logic [SELBITSZ-1:0]  m_sel_i,
	output logic [ARCHBITSZ-1:0] m_data_o,
	output logic                 m_rdy_o,
	// serial pins
	input  logic                 uart_rx_i,
	output logic                 uart_tx_o
);

	// one slave port per device
	pi1_if ram_if ();
	pi1_if uart_if ();

	// address decode and response mux, invalid device lives in here
	pi1_router router_i (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.m_op_i   (m_op_i),
		.m_addr_i (m_addr_i),
		.m_data_i (m_data_i),
		.m_sel_i  (m_sel_i),
		.m_data_o (m_data_o),
		.m_rdy_o  (m_rdy_o),
		.ram_o    (ram_if.mst),
		.uart_o   (uart_if.mst)
	);

	// 4 KB at byte 0x1000
	pi1_smem smem_i (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.bus_i (ram_if.slv)
	);

	// two words just below the memory
	pi1_uart uart_i (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.bus_i (uart_if.slv),
		.rx_i  (uart_rx_i),
		.tx_o  (uart_tx_o)
	);

endmodule

// File: verification/soc_checker.sv
// testbench checker, compares bus reads with the trace and decodes bytes sent on the serial line
`timescale 1ns/1ps

module soc_checker import pi1_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  pi1_op_e              op_i,
	input  logic [ADDRBITSZ-1:0] addr_i,
	input  logic [ARCHBITSZ-1:0] wdata_i,
	input  logic [SELBITSZ-1:0]  sel_i,
	input  logic [ARCHBITSZ-1:0] rdata_i,
	input  logic                 rdy_i,
	input  logic                 tx_i,
	input  logic                 exp_chk_i,
	input  logic [ARCHBITSZ-1:0] exp_data_i,
	output int                   mismatch_cnt_o,
	output int                   fail_cnt_o
);

	int         read_mis = 0;
	int         tx_mis = 0;
	int         lat_err = 0;
	int         frame_err = 0;
	// cycles spent waiting on the current request
	int         lat = 0;
	bit         stall_seen = 1'b0;
	// bytes written to the uart data word, in order
	logic [7:0] tx_exp [$];

	assign mismatch_cnt_o = read_mis + tx_mis;
	assign fail_cnt_o     = lat_err + frame_err;

	function automatic bit in_ram(logic [ADDRBITSZ-1:0] a);
		return a >= RAM_BASE && a < RAM_BASE + RAM_WORDS;
	endfunction

	function automatic bit in_uart(logic [ADDRBITSZ-1:0] a);
		return a >= UART_BASE && a < UART_BASE + UART_WORDS;
	endfunction

	// values seen here are the ones settled before the edge
	always @(posedge clk_i) begin
		if (rst_i || op_i == PI1_NOP) begin
			lat = 0;
		end else if (!rdy_i) begin
			lat++;
		end else begin
			if (exp_chk_i && (op_i == PI1_RD || op_i == PI1_RW) && rdata_i !== exp_data_i) begin
				$display("Mismatch at %0t: m_data_o got %h expected %h", $time, rdata_i,
					exp_data_i);
				read_mis++;
			end
			// memory answers after one cycle and the invalid device at once
			if (in_ram(addr_i) && lat != 1) begin
				$display("Memory access to word %h took %0d cycles instead of 2", addr_i, lat + 1);
				lat_err++;
			end else if (!in_ram(addr_i) && !in_uart(addr_i) && lat != 0) begin
				$display("Invalid device access to word %h was not answered at once", addr_i);
				lat_err++;
			end
			if (addr_i == UART_BASE && op_i == PI1_WR && sel_i[0]) begin
				tx_exp.push_back(wdata_i[7:0]);
				// held off while the holding register was full
				if (lat > 1) begin
					stall_seen = 1'b1;
				end
			end
			lat = 0;
		end
	end

	// 8N1 receiver on the transmit pin, sampling in the middle of each bit
	always begin
		logic [7:0] got;
		logic [7:0] exp_b;
		@(negedge tx_i);
		if (!rst_i) begin
			repeat (CLKS_PER_BIT / 2) @(posedge clk_i);
			if (tx_i !== 1'b0) begin
				$display("Start bit on uart_tx_o at %0t did not stay low", $time);
				frame_err++;
			end else begin
				for (int b = 0; b < 8; b++) begin
					repeat (CLKS_PER_BIT) @(posedge clk_i);
					got[b] = tx_i;
				end
				repeat (CLKS_PER_BIT) @(posedge clk_i);
				if (tx_i !== 1'b1) begin
					$display("Stop bit on uart_tx_o at %0t was not high", $time);
					frame_err++;
				end
				if (tx_exp.size() == 0) begin
					$display("Byte %h on uart_tx_o at %0t was never written", got, $time);
					frame_err++;
				end else begin
					exp_b = tx_exp.pop_front();
					if (got !== exp_b) begin
						$display("Mismatch at %0t: uart_tx_o byte got %h expected %h", $time,
							got, exp_b);
						tx_mis++;
					end
				end
			end
		end
	end

	// checks that can only be made once the trace is over
	task automatic final_checks(output int fails);
		fails = 0;
		if (tx_exp.size() != 0) begin
			$display("%0d byte(s) written to the uart never appeared on uart_tx_o",
				tx_exp.size());
			fails++;
		end
		if (!stall_seen) begin
			$display("No uart data write was held off while the holding register was full");
			fails++;
		end
	endtask

endmodule

// File: verification/soc_tb.sv
// testbench top for soc_top, plays the bus trace, loops the uart back and ends the run
`timescale 1ns/1ps

module soc_tb import pi1_pkg::*; ();

	localparam time CLK_PERIOD = 40ns;
	localparam TRACE_PATH = "verification/soc_trace.txt";
	// random filler words placed in memory before the trace runs
	localparam int FILL_WORDS = 4;
	localparam logic [ADDRBITSZ-1:0] FILL_BASE = RAM_BASE + 30'h20;

	logic                 clk;
	logic                 rst;
	pi1_op_e              m_op;
	logic [ADDRBITSZ-1:0] m_addr;
	logic [ARCHBITSZ-1:0] m_wdata;
	logic [SELBITSZ-1:0]  m_sel;
	logic [ARCHBITSZ-1:0] m_rdata;
	logic                 m_rdy;
	// serial line, transmitter output feeds the receiver
	logic                 uart_line;
	logic                 exp_chk;
	logic [ARCHBITSZ-1:0] exp_data;
	logic                 done_q = 1'b0;
	int                   mismatch_cnt;
	int                   fail_cnt;
	integer               seed = 32'h3840;
	int                   tb_err = 0;
	int                   n_lines = 0;
	bit                   loaded = 1'b0;
	// memory model built from the byte select rules
	logic [ARCHBITSZ-1:0] shadow [RAM_WORDS];
	// trace contents, kind 0 is no check, 1 a fixed value, 2 the memory model
	pi1_op_e              tr_op [$];
	logic [ADDRBITSZ-1:0] tr_addr [$];
	logic [ARCHBITSZ-1:0] tr_wdata [$];
	logic [SELBITSZ-1:0]  tr_sel [$];
	int                   tr_kind [$];
	logic [ARCHBITSZ-1:0] tr_exp [$];

	soc_top dut_i (
		.clk_i     (clk),
		.rst_i     (rst),
		.m_op_i    (m_op),
		.m_addr_i  (m_addr),
		.m_data_i  (m_wdata),
		.m_sel_i   (m_sel),
		.m_data_o  (m_rdata),
		.m_rdy_o   (m_rdy),
		.uart_rx_i (uart_line),
		.uart_tx_o (uart_line)
	);

	soc_checker chk_i (
		.clk_i          (clk),
		.rst_i          (rst),
		.op_i           (m_op),
		.addr_i         (m_addr),
		.wdata_i        (m_wdata),
		.sel_i          (m_sel),
		.rdata_i        (m_rdata),
		.rdy_i          (m_rdy),
		.tx_i           (uart_line),
		.exp_chk_i      (exp_chk),
		.exp_data_i     (exp_data),
		.mismatch_cnt_o (mismatch_cnt),
		.fail_cnt_o     (fail_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// completion seen at the edge, read back on the following falling edge
	always @(posedge clk) begin
		done_q <= m_rdy && (m_op != PI1_NOP);
	end

	// old word for reads and swaps, then the selected bytes merged in
	function automatic logic [ARCHBITSZ-1:0] model_access(pi1_op_e op,
		logic [ADDRBITSZ-1:0] addr, logic [ARCHBITSZ-1:0] wdata, logic [SELBITSZ-1:0] sel);
		logic [ARCHBITSZ-1:0] old;
		int idx;
		// outside the memory the invalid device or uart answers
		if (addr < RAM_BASE || addr >= RAM_BASE + RAM_WORDS) begin
			return '0;
		end
		idx = addr - RAM_BASE;
		old = shadow[idx];
		if (op == PI1_WR || op == PI1_RW) begin
			for (int b = 0; b < SELBITSZ; b++) begin
				if (sel[b]) begin
					shadow[idx][b*8 +: 8] = wdata[b*8 +: 8];
				end
			end
		end
		return old;
	endfunction

	// request held from a falling edge until the completing rising edge
	task automatic bus_access(input pi1_op_e op, input logic [ADDRBITSZ-1:0] addr,
		input logic [ARCHBITSZ-1:0] wdata, input logic [SELBITSZ-1:0] sel,
		input logic chk, input logic [ARCHBITSZ-1:0] exp);
		m_op     = op;
		m_addr   = addr;
		m_wdata  = wdata;
		m_sel    = sel;
		exp_chk  = chk;
		exp_data = exp;
		do @(negedge clk); while (!done_q);
		m_op    = PI1_NOP;
		exp_chk = 1'b0;
	endtask

	task automatic load_trace();
		int fd;
		int n;
		int line_no;
		reg [8*200-1:0] line;
		reg [8*8-1:0] op_s;
		reg [8*16-1:0] exp_s;
		logic [ADDRBITSZ-1:0] a;
		logic [ARCHBITSZ-1:0] d;
		logic [SELBITSZ-1:0] s;
		logic [ARCHBITSZ-1:0] e;
		line_no = 0;
		fd = $fopen(TRACE_PATH, "r");
		if (fd == 0) begin
			$display("Cannot open the trace file %s", TRACE_PATH);
			tb_err++;
			return;
		end
		while ($fgets(line, fd)) begin
			line_no++;
			op_s = '0;
			n = $sscanf(line, "%s %h %h %h %s", op_s, a, d, s, exp_s);
			// blank lines and comment lines
			if (n <= 0 || op_s == "#") continue;
			if (n != 5) begin
				$display("Trace line %0d does not have five columns", line_no);
				tb_err++;
				continue;
			end
			case (op_s)
				"WR":    tr_op.push_back(PI1_WR);
				"RD":    tr_op.push_back(PI1_RD);
				"RW":    tr_op.push_back(PI1_RW);
				"NOP":   tr_op.push_back(PI1_NOP);
				default: begin
					$display("Trace line %0d has an unknown op", line_no);
					tb_err++;
					continue;
				end
			endcase
			e = '0;
			if (exp_s == "-") begin
				tr_kind.push_back(0);
			end else if (exp_s == "m") begin
				tr_kind.push_back(2);
			end else begin
				tr_kind.push_back(1);
				void'($sscanf(exp_s, "%h", e));
			end
			tr_addr.push_back(a);
			tr_wdata.push_back(d);
			tr_sel.push_back(s);
			tr_exp.push_back(e);
		end
		$fclose(fd);
	endtask

	// closing line with every count, timeouts included
	task automatic print_summary(input int timeouts, output int total);
		int end_fail;
		chk_i.final_checks(end_fail);
		total = mismatch_cnt + fail_cnt + tb_err + end_fail + timeouts;
		$display("errors %0d: mismatches %0d, other failures %0d, timeouts %0d", total,
			mismatch_cnt, fail_cnt + tb_err + end_fail, timeouts);
	endtask

	initial begin
		logic [ARCHBITSZ-1:0] fill;
		logic [ARCHBITSZ-1:0] exp;
		int total;
		rst      = 1'b1;
		m_op     = PI1_NOP;
		m_addr   = '0;
		m_wdata  = '0;
		m_sel    = '0;
		exp_chk  = 1'b0;
		exp_data = '0;
		// memory starts cleared
		for (int i = 0; i < RAM_WORDS; i++) begin
			shadow[i] = '0;
		end
		load_trace();
		n_lines = tr_op.size() + FILL_WORDS;
		loaded  = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < FILL_WORDS; i++) begin
			fill = $random(seed);
			void'(model_access(PI1_WR, FILL_BASE + ADDRBITSZ'(i), fill, '1));
			bus_access(PI1_WR, FILL_BASE + ADDRBITSZ'(i), fill, '1, 1'b0, '0);
		end
		foreach (tr_op[i]) begin
			if (tr_op[i] == PI1_NOP) begin
				// idle line, write data column holds the cycle count
				repeat (tr_wdata[i]) @(negedge clk);
			end else begin
				exp = model_access(tr_op[i], tr_addr[i], tr_wdata[i], tr_sel[i]);
				if (tr_kind[i] == 1) begin
					exp = tr_exp[i];
				end
				bus_access(tr_op[i], tr_addr[i], tr_wdata[i], tr_sel[i], tr_kind[i] != 0, exp);
			end
		end
		repeat (4) @(negedge clk);
		print_summary(0, total);
		if (total == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// budget scales with the trace, each line allowed two full serial frames
	initial begin
		int total;
		wait (loaded);
		repeat (n_lines * 2 * 10 * CLKS_PER_BIT + 1000) @(posedge clk);
		$display("Timeout after %0d clock cycles without reaching the end of the trace",
			n_lines * 2 * 10 * CLKS_PER_BIT + 1000);
		print_summary(1, total);
		$display("Checks failed");
		$finish;
	end

endmodule

// File: verification/soc_trace.txt
# columns are op, word address, write data, byte select and expected read data, all hex
# expected is a word, or - for none, or m for the memory model; NOP idles for wdata cycles
WR 00000400 11223344 f -
WR 000007ff a5a55a5a f -
WR 00000500 deadbeef f -
WR 00000601 0badf00d f -
RD 00000400 00000000 f 11223344
RD 000007ff 00000000 f a5a55a5a
RD 00000500 00000000 f deadbeef
RD 00000601 00000000 f 0badf00d
WR 00000500 000000aa 1 -
WR 00000500 11000000 8 -
RD 00000500 00000000 f 11adbeaa
RW 00000500 cafe0000 c 11adbeaa
RD 00000500 00000000 f cafebeaa
RD 00000420 00000000 f m
RW 00000421 00ff00ff 5 m
RD 00000421 00000000 f m
WR 00000422 12345678 6 -
RD 00000422 00000000 f m
RD 000003fd 00000000 f 00000000
RD 00000800 00000000 f 00000000
WR 00000800 ffffffff f -
WR 000003fd ffffffff f -
RD 00000400 00000000 f 11223344
RD 000007ff 00000000 f a5a55a5a
WR 000003fe 00000055 1 -
RD 000003ff 00000000 f 00000001
NOP 00000000 00000064 0 -
WR 000003fe 000000c3 1 -
WR 000003fe 0000003c 1 -
WR 000003fe 000000a7 1 -
NOP 00000000 00000190 0 -
RD 000003ff 00000000 f 00000002
RD 000003fe 00000000 f 00000055
RD 000003fe 00000000 f 000000c3
RD 000003fe 00000000 f 0000003c
RD 000003fe 00000000 f 000000a7
RD 000003fe 00000000 f 00000000
RD 000003ff 00000000 f 00000000
